//--- logic/obj_pkg.sv
//--------------------------------------------------
// object line engine shared definitions
//   sizes of table, object, line and ROM address
//   attribute, ROM address, ROM row and pixel structs
//   controller state enum
//--------------------------------------------------

`default_nettype none

package obj_pkg;

    localparam int OBJ_COUNT  = 16;   // attribute table entries
    localparam int OBJ_LIMIT  = 4;    // max objects drawn per line
    localparam int OBJ_HEIGHT = 8;    // lines
    localparam int OBJ_WIDTH  = 16;   // pixels
    localparam int LINE_WIDTH = 256;  // pixels per line
    localparam int GFX_AW     = 10;   // graphics ROM address width

    // one object attribute entry, 27 bits
    typedef struct packed {
        logic [7:0] y;      // top line
        logic [7:0] x;      // left pixel
        logic [6:0] code;   // graphics number
        logic [2:0] pal;    // 0 disables the object
        logic       hflip;  // mirror horizontally
    } obj_attr_t;

    // ROM address, one row of one object
    typedef struct packed {
        logic [6:0] code;
        logic [2:0] row;    // row inside the object
    } gfx_addr_t;

    // one ROM row, two bitplanes
    typedef struct packed {
        logic [15:0] plane1;
        logic [15:0] plane0;
    } gfx_row_t;

    // line buffer pixel
    typedef struct packed {
        logic [2:0] pal;
        logic [1:0] color;  // 0 is transparent / black
    } obj_pxl_t;

    typedef enum logic [2:0] {
        IDLE,   // after reset, waiting for a line
        SCAN,   // walking the table
        FETCH,  // waiting on the ROM row
        DRAW,   // shifter busy
        DONE    // line finished, waiting for the next one
    } obj_state_e;

endpackage

`default_nettype wire

//--- logic/obj_ctrl.sv
//--------------------------------------------------
// object engine controller FSM
//   line handshake and back buffer toggle
//   table walk, fetch and draw per hit
//   hit count, overflow flag, line done pulse
//--------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module obj_ctrl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     line_valid,
    input  wire  [7:0]              line,
    output logic                    line_ready,
    output logic                    line_done,
    output logic                    line_ovf,
    output logic                    buf_sel,
    output logic [3:0]              scan_idx,
    output logic [7:0]              scan_line,   // latched line for the scanner
    input  wire                     scan_hit,
    input  wire  [2:0]              scan_row,
    input  wire  obj_pkg::obj_attr_t scan_attr,
    output logic                    fetch_start,
    output obj_pkg::gfx_addr_t      fetch_addr,
    input  wire                     fetch_done,
    input  wire  obj_pkg::gfx_row_t fetch_row,
    output logic                    draw_start,
    output obj_pkg::obj_attr_t      draw_attr,
    output obj_pkg::gfx_row_t       draw_row,
    input  wire                     draw_done
);
    import obj_pkg::*;

    obj_state_e state;
    logic [2:0] hit_cnt;    // objects drawn on this line
    logic       ovf_seen;   // overflow hit met earlier in the walk
    logic       last_idx;
    logic       ovf_hit;
    logic       take_hit;

    assign last_idx   = scan_idx == 4'(OBJ_COUNT - 1);
    assign ovf_hit    = scan_hit && (hit_cnt == 3'(OBJ_LIMIT));
    assign take_hit   = scan_hit && !ovf_hit;
    assign line_ready = (state == IDLE) || (state == DONE);
    assign draw_row   = fetch_row;  // fetcher holds the row until the next fetch

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            buf_sel     <= 1'b0;
            scan_idx    <= 4'd0;
            hit_cnt     <= 3'd0;
            ovf_seen    <= 1'b0;
            line_done   <= 1'b0;
            line_ovf    <= 1'b0;
            fetch_start <= 1'b0;
            draw_start  <= 1'b0;
        end else begin
            line_done   <= 1'b0;  // pulses
            fetch_start <= 1'b0;
            draw_start  <= 1'b0;
            case (state)
                IDLE, DONE: if (line_valid) begin
                    buf_sel  <= ~buf_sel;  // rendered buffer goes to the front
                    scan_idx <= 4'd0;
                    hit_cnt  <= 3'd0;
                    ovf_seen <= 1'b0;
                    line_ovf <= 1'b0;
                    state    <= SCAN;
                end
                SCAN: begin
                    if (take_hit) begin
                        fetch_start <= 1'b1;
                        hit_cnt     <= hit_cnt + 3'd1;
                        state       <= FETCH;
                    end else if (last_idx) begin
                        line_done <= 1'b1;
                        line_ovf  <= ovf_seen | ovf_hit;
                        state     <= DONE;
                    end else begin
                        scan_idx <= scan_idx + 4'd1;
                        ovf_seen <= ovf_seen | ovf_hit;
                    end
                end
                FETCH: if (fetch_done) begin
                    draw_start <= 1'b1;
                    state      <= DRAW;
                end
                DRAW: if (draw_done) begin
                    if (last_idx) begin
                        line_done <= 1'b1;
                        line_ovf  <= ovf_seen;
                        state     <= DONE;
                    end else begin
                        scan_idx <= scan_idx + 4'd1;
                        state    <= SCAN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload captured at handshake and on a taken hit
    always_ff @(posedge clk) begin
        if (line_ready && line_valid)
            scan_line <= line;
        if (state == SCAN && take_hit) begin
            fetch_addr.code <= scan_attr.code;
            fetch_addr.row  <= scan_row;
            draw_attr       <= scan_attr;  // table may change while drawing
        end
    end

endmodule

`default_nettype wire

//--- logic/obj_attr_scan.sv
//--------------------------------------------------
// object attribute table
//   16 entries written from the CPU side
//   combinational line hit compare on scan_idx
//--------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module obj_attr_scan (
    input  wire                      clk,
    input  wire                      wr_valid,
    input  wire  [3:0]               wr_idx,
    input  wire  obj_pkg::obj_attr_t wr_data,
    input  wire  [7:0]               line,
    input  wire  [3:0]               scan_idx,
    output logic                     hit,
    output logic [2:0]               row,
    output obj_pkg::obj_attr_t       attr
);
    import obj_pkg::*;

    obj_attr_t  table_q [OBJ_COUNT];  // plain registers
    logic [7:0] diff;                 // line - y, wraps at 256
    logic       in_range;
    logic       enabled;

    // CPU write, seen by the scan on the next cycle
    always_ff @(posedge clk) begin
        if (wr_valid)
            table_q[wr_idx] <= wr_data;
    end

    assign attr = table_q[scan_idx];

    // objects starting near 255 wrap into the top lines
    assign diff     = line - attr.y;
    assign in_range = diff < 8'(OBJ_HEIGHT);
    assign enabled  = attr.pal != 3'd0;    // palette 0 never draws

    assign hit = in_range && enabled;
    assign row = diff[2:0];   // only meaningful with hit

endmodule

`default_nettype wire

//--- logic/obj_gfx_fetch.sv
//--------------------------------------------------
// graphics ROM fetch
//   request register held through back-pressure
//   response capture and done pulse
//--------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module obj_gfx_fetch (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       start,
    input  wire  obj_pkg::gfx_addr_t  addr,
    output logic                      done,
    output obj_pkg::gfx_row_t         row,
    output logic                      req_valid,
    output logic [obj_pkg::GFX_AW-1:0] req_addr,
    input  wire                       req_ready,
    input  wire                       rsp_valid,
    input  wire  obj_pkg::gfx_row_t   rsp_data
);
    import obj_pkg::*;

    logic wait_rsp;  // request accepted, response pending
    logic rsp_take;

    assign rsp_take = wait_rsp && rsp_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            wait_rsp  <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= rsp_take;
            if (start)
                req_valid <= 1'b1;
            else if (req_valid && req_ready) begin
                req_valid <= 1'b0;  // accepted
                wait_rsp  <= 1'b1;
            end
            if (rsp_take)
                wait_rsp <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            req_addr <= addr;   // steady until accepted
        if (rsp_take)
            row <= rsp_data;    // held for the shifter
    end

endmodule

`default_nettype wire

//--- logic/obj_shifter.sv
//--------------------------------------------------
// object row shifter
//   two bitplane shift registers, optional mirror
//   one line buffer write per pixel, clipped at 255
//--------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module obj_shifter (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      start,
    input  wire  obj_pkg::obj_attr_t attr,
    input  wire  obj_pkg::gfx_row_t  row,
    output logic                     done,
    output logic                     wr_valid,
    output logic [7:0]               wr_x,
    output obj_pkg::obj_pxl_t        wr_pxl
);
    import obj_pkg::*;

    logic        busy;
    logic [3:0]  cnt;        // pixel within the row
    logic [15:0] plane1_q;
    logic [15:0] plane0_q;
    logic        hflip_q;
    logic [2:0]  pal_q;
    logic [8:0]  pos;        // 9 bits so the clip is visible
    logic        last_pxl;

    assign last_pxl = cnt == 4'(OBJ_WIDTH - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= 4'd0;
            done <= 1'b0;
        end else begin
            done <= busy && last_pxl;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 4'd0;
            end else if (busy) begin
                cnt <= cnt + 4'd1;
                if (last_pxl)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            plane1_q <= row.plane1;
            plane0_q <= row.plane0;
            hflip_q  <= attr.hflip;
            pal_q    <= attr.pal;
            pos      <= {1'b0, attr.x};
        end else if (busy) begin
            // MSB first normally, LSB first when mirrored
            plane1_q <= hflip_q ? {1'b0, plane1_q[15:1]} : {plane1_q[14:0], 1'b0};
            plane0_q <= hflip_q ? {1'b0, plane0_q[15:1]} : {plane0_q[14:0], 1'b0};
            pos      <= pos + 9'd1;
        end
    end

    assign wr_valid     = busy && !pos[8];  // drop pixels past x = 255
    assign wr_x         = pos[7:0];
    assign wr_pxl.pal   = pal_q;
    assign wr_pxl.color = hflip_q ? {plane1_q[0], plane0_q[0]}
                                  : {plane1_q[15], plane0_q[15]};

endmodule

`default_nettype wire

//--- logic/obj_line_buf.sv
//--------------------------------------------------
// double line buffer
//   back buffer write with priority and transparency
//   front buffer read, clear after read, blanking
//--------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module obj_line_buf (
    input  wire                     clk,
    input  wire                     buf_sel,   // back buffer
    input  wire                     wr_valid,
    input  wire  [7:0]              wr_x,
    input  wire  obj_pkg::obj_pxl_t wr_pxl,
    input  wire  [7:0]              pxl_x,
    input  wire                     blank,
    output obj_pkg::obj_pxl_t       pxl
);
    import obj_pkg::*;

    obj_pxl_t buf_mem [2][LINE_WIDTH];
    logic     front_sel;
    obj_pxl_t back_old;    // pixel already at wr_x
    obj_pxl_t front_rd;
    logic     wr_en;
    logic     clr_en;

    assign front_sel = ~buf_sel;

    // earlier objects already wrote, keep them
    assign back_old = buf_mem[buf_sel][wr_x];
    assign wr_en    = wr_valid
                   && (wr_pxl.color != 2'd0)     // colour 0 is transparent
                   && (back_old.color == 2'd0);

    assign front_rd = buf_mem[front_sel][pxl_x];
    assign clr_en   = !blank;   // blanked reads leave the entry alone

    // the two ports never hit the same buffer
    always_ff @(posedge clk) begin
        if (wr_en)
            buf_mem[buf_sel][wr_x] <= wr_pxl;
        if (clr_en)
            buf_mem[front_sel][pxl_x] <= '0;  // ready for the next render
    end

    // one cycle from pxl_x to pxl
    // held low while blank is high, also through reset
    always_ff @(posedge clk) begin
        if (blank)
            pxl <= '0;
        else
            pxl <= front_rd;
    end

endmodule

`default_nettype wire

//--- logic/obj_engine.sv
//--------------------------------------------------
// object line engine top level
//   controller, attribute table, ROM fetch,
//   row shifter and double line buffer
//--------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module obj_engine (
    input  wire                        clk,
    input  wire                        rst,
    // CPU attribute writes
    input  wire                        attr_wr_valid,
    input  wire  [3:0]                 attr_wr_idx,
    input  wire  obj_pkg::obj_attr_t   attr_wr_data,
    // line request
    input  wire                        line_valid,
    input  wire  [7:0]                 line,
    output logic                       line_ready,
    output logic                       line_done,
    output logic                       line_ovf,
    // graphics ROM
    output logic                       gfx_req_valid,
    output logic [obj_pkg::GFX_AW-1:0] gfx_req_addr,
    input  wire                        gfx_req_ready,
    input  wire                        gfx_rsp_valid,
    input  wire  obj_pkg::gfx_row_t    gfx_rsp_data,
    // pixel readout
    input  wire  [7:0]                 pxl_x,
    input  wire                        blank,
    output obj_pkg::obj_pxl_t          pxl
);
    import obj_pkg::*;

    logic       buf_sel;
    logic [3:0] scan_idx;
    logic [7:0] scan_line;
    logic       scan_hit;
    logic [2:0] scan_row;
    obj_attr_t  scan_attr;
    logic       fetch_start;
    gfx_addr_t  fetch_addr;
    logic       fetch_done;
    gfx_row_t   fetch_row;
    logic       draw_start;
    obj_attr_t  draw_attr;
    gfx_row_t   draw_row;
    logic       draw_done;
    logic       wr_valid;
    logic [7:0] wr_x;
    obj_pxl_t   wr_pxl;

    obj_ctrl i_ctrl (
        .clk, .rst, .line_valid, .line, .line_ready, .line_done, .line_ovf,
        .buf_sel, .scan_idx, .scan_line, .scan_hit, .scan_row, .scan_attr,
        .fetch_start, .fetch_addr, .fetch_done, .fetch_row,
        .draw_start, .draw_attr, .draw_row, .draw_done
    );

    obj_attr_scan i_attr_scan (
        .clk, .wr_valid(attr_wr_valid), .wr_idx(attr_wr_idx), .wr_data(attr_wr_data),
        .line(scan_line), .scan_idx, .hit(scan_hit), .row(scan_row), .attr(scan_attr)
    );

    obj_gfx_fetch i_gfx_fetch (
        .clk, .rst, .start(fetch_start), .addr(fetch_addr), .done(fetch_done),
        .row(fetch_row), .req_valid(gfx_req_valid), .req_addr(gfx_req_addr),
        .req_ready(gfx_req_ready), .rsp_valid(gfx_rsp_valid), .rsp_data(gfx_rsp_data)
    );

    obj_shifter i_shifter (
        .clk, .rst, .start(draw_start), .attr(draw_attr), .row(draw_row),
        .done(draw_done), .wr_valid, .wr_x, .wr_pxl
    );

    obj_line_buf i_line_buf (
        .clk, .buf_sel, .wr_valid, .wr_x, .wr_pxl, .pxl_x, .blank, .pxl
    );

endmodule

`default_nettype wire

//--- verif/tb_obj_engine.sv
//--------------------------------------------------
// object line engine testbench
//   clock, reset, randomized graphics ROM model
//   reference line model and check task
//   directed tests for render, flip, clip, priority,
//   line limit and blanking
//--------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module tb_obj_engine;
    import obj_pkg::*;

    // 20 line reads of 256 cycles plus 35 renders of up to ~200 cycles, with slack
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk = 1'b0;
    logic       rst;
    logic       attr_wr_valid;
    logic [3:0] attr_wr_idx;
    obj_attr_t  attr_wr_data;
    logic       line_valid;
    logic [7:0] line;
    logic       line_ready;
    logic       line_done;
    logic       line_ovf;
    logic       gfx_req_valid;
    logic [GFX_AW-1:0] gfx_req_addr;
    logic       gfx_req_ready;
    logic       gfx_rsp_valid;
    gfx_row_t   gfx_rsp_data;
    logic [7:0] pxl_x;
    logic       blank;
    obj_pxl_t   pxl;

    obj_attr_t attrs [OBJ_COUNT];     // copy of the table as written
    obj_pxl_t  exp_pxl [LINE_WIDTH];  // reference line
    logic      exp_ovf;
    logic      ovf;
    int        cycles = 0;

    obj_engine i_obj_engine (.*);

    always #50 clk = ~clk;  // 100 ns period

    // ROM contents, a fixed function of the address
    function automatic gfx_row_t rom_row(input logic [9:0] a);
        gfx_row_t r;
        int       i;
        r.plane0 = 16'(a * 16'hB5A7);
        for (i = 0; i < 16; i++)
            r.plane1[i] = r.plane0[15 - i];  // bit reversed, leaves some colour 0
        return r;
    endfunction

    // inputs change 10 ns after the edge, outputs are settled there too
    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %s got %h expected %h", name, got, want);
            $display("Test failures found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic write_attr(input int idx, input obj_attr_t a);
        attr_wr_valid = 1'b1;
        attr_wr_idx   = 4'(idx);
        attr_wr_data  = a;
        attrs[idx]    = a;
        tick();
        attr_wr_valid = 1'b0;
    endtask

    task automatic clear_table();
        int k;
        for (k = 0; k < OBJ_COUNT; k++)
            write_attr(k, '0);  // pal 0, nothing drawn
    endtask

    // expected line: lower index first, first OBJ_LIMIT hits only
    task automatic build_expected(input logic [7:0] n);
        int         k;
        int         i;
        int         b;
        int         pos;
        int         hits;
        logic [7:0] d;
        gfx_row_t   r;
        obj_pxl_t   p;
        hits    = 0;
        exp_ovf = 1'b0;
        for (i = 0; i < LINE_WIDTH; i++)
            exp_pxl[i] = '0;
        for (k = 0; k < OBJ_COUNT; k++) begin
            d = n - attrs[k].y;  // wraps like the line counter
            if (attrs[k].pal != 3'd0 && d < 8'(OBJ_HEIGHT)) begin
                hits++;
                if (hits > OBJ_LIMIT) begin
                    exp_ovf = 1'b1;
                end else begin
                    r = rom_row({attrs[k].code, d[2:0]});
                    for (i = 0; i < OBJ_WIDTH; i++) begin
                        b       = attrs[k].hflip ? i : 15 - i;
                        pos     = int'(attrs[k].x) + i;
                        p.pal   = attrs[k].pal;
                        p.color = {r.plane1[b], r.plane0[b]};
                        if (pos < LINE_WIDTH && p.color != 2'd0 && exp_pxl[pos].color == 2'd0)
                            exp_pxl[pos] = p;
                    end
                end
            end
        end
    endtask

    // handshake, then wait for the done pulse
    task automatic run_line(input logic [7:0] n, output logic ovf_flag);
        line       = n;
        line_valid = 1'b1;
        while (!line_ready)
            tick();
        tick();  // transfer on this edge
        line_valid = 1'b0;
        while (!line_done)
            tick();
        ovf_flag = line_ovf;
    endtask

    // mode 0 compares with the reference, 1 with zero, 2 only drains
    task automatic read_line(input logic blank_v, input int mode);
        int       x;
        obj_pxl_t want;
        for (x = 0; x < LINE_WIDTH; x++) begin
            pxl_x = 8'(x);
            blank = blank_v;
            tick();
            want = (mode == 0) ? exp_pxl[x] : '0;
            if (mode != 2)
                check($sformatf("pxl[%0d]", x), 32'(pxl), 32'(want));
        end
        blank = 1'b1;
    endtask

    // render n, swap it to the front with n+1, read it back
    task automatic check_line(input logic [7:0] n);
        build_expected(n);
        run_line(n, ovf);
        check("line_ovf", 32'(ovf), 32'(exp_ovf));
        run_line(n + 8'd1, ovf);
        read_line(1'b0, 0);
    endtask

    task automatic test_reset();
        check("line_ready", 32'(line_ready), 32'd1);
        check("line_done", 32'(line_done), 32'd0);
        check("line_ovf", 32'(line_ovf), 32'd0);
        check("gfx_req_valid", 32'(gfx_req_valid), 32'd0);
        check("pxl", 32'(pxl), 32'd0);
    endtask

    // both buffers hold junk until read once
    task automatic prime_buffers();
        run_line(8'd0, ovf);
        run_line(8'd1, ovf);
        read_line(1'b0, 2);
        run_line(8'd2, ovf);
        read_line(1'b0, 2);
    endtask

    task automatic test_single();
        int l;
        clear_table();
        write_attr(0, '{8'd40, 8'd60, 7'd5, 3'd3, 1'b0});
        for (l = 39; l <= 48; l++)  // y-1 through y+8
            check_line(8'(l));
    endtask

    task automatic test_flip_clip();
        clear_table();
        write_attr(0, '{8'd100, 8'd30, 7'd9, 3'd2, 1'b1});
        write_attr(1, '{8'd98, 8'd248, 7'd17, 3'd5, 1'b0});  // runs past 255
        write_attr(2, '{8'd101, 8'd245, 7'd33, 3'd4, 1'b1});
        check_line(8'd101);
        check_line(8'd105);
    endtask

    task automatic test_overlap();
        clear_table();
        write_attr(1, '{8'd10, 8'd52, 7'd77, 3'd0, 1'b0});  // disabled, would win
        write_attr(2, '{8'd10, 8'd50, 7'd3, 3'd1, 1'b0});
        write_attr(5, '{8'd12, 8'd56, 7'd40, 3'd6, 1'b1});
        check_line(8'd13);
    endtask

    task automatic limit_scene();
        clear_table();
        write_attr(0, '{8'd196, 8'd10, 7'd11, 3'd1, 1'b0});
        write_attr(3, '{8'd200, 8'd20, 7'd12, 3'd2, 1'b1});
        write_attr(4, '{8'd199, 8'd100, 7'd13, 3'd3, 1'b0});
        write_attr(7, '{8'd194, 8'd150, 7'd14, 3'd4, 1'b0});
        write_attr(9, '{8'd197, 8'd24, 7'd15, 3'd5, 1'b1});  // fifth hit
        write_attr(12, '{8'd200, 8'd200, 7'd16, 3'd6, 1'b0});
    endtask

    task automatic test_limit();
        limit_scene();
        check_line(8'd200);  // six hits, overflow
        write_attr(9, '0);
        write_attr(12, '0);
        check_line(8'd200);  // exactly four
    endtask

    task automatic test_blank();
        limit_scene();
        build_expected(8'd201);
        run_line(8'd201, ovf);
        check("line_ovf", 32'(ovf), 32'(exp_ovf));
        run_line(8'd202, ovf);
        read_line(1'b1, 1);  // blanked, entries kept
        read_line(1'b0, 0);
        read_line(1'b0, 1);  // cleared by the previous read
    endtask

    // ROM with random stalls and 1 to 4 cycles of latency
    initial begin
        int         delay;
        logic       pending;
        logic [9:0] rom_addr;
        void'($urandom(32'h7458594e));  // same stall pattern every run
        gfx_req_ready = 1'b0;
        gfx_rsp_valid = 1'b0;
        gfx_rsp_data  = '0;
        pending       = 1'b0;
        delay         = 0;
        rom_addr      = '0;
        forever begin
            tick();
            gfx_rsp_valid = 1'b0;
            if (pending) begin
                if (delay > 1) begin
                    delay--;
                end else begin
                    gfx_rsp_valid = 1'b1;
                    gfx_rsp_data  = rom_row(rom_addr);
                    pending       = 1'b0;
                end
            end
            gfx_req_ready = ($urandom % 3) != 0;  // stall about a third of the time
            if (gfx_req_valid && gfx_req_ready && !pending) begin
                pending  = 1'b1;  // accepted on the coming edge
                rom_addr = gfx_req_addr;
                delay    = 1 + int'($urandom % 4);
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the engine stopped answering after %0d cycles", cycles);
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    initial begin
        rst           = 1'b1;
        attr_wr_valid = 1'b0;
        attr_wr_idx   = '0;
        attr_wr_data  = '0;
        line_valid    = 1'b0;
        line          = '0;
        pxl_x         = '0;
        blank         = 1'b1;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;
        test_reset();
        clear_table();
        prime_buffers();
        test_single();
        test_flip_clip();
        test_overlap();
        test_limit();
        test_blank();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
logic/obj_pkg.sv
logic/obj_ctrl.sv
logic/obj_attr_scan.sv
logic/obj_gfx_fetch.sv
logic/obj_shifter.sv
logic/obj_line_buf.sv
logic/obj_engine.sv
verif/tb_obj_engine.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the object engine testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module tb_obj_engine -Mdir obj_dir -f list.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_obj_engine; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
